//--- filelist.f
+incdir+common
common/cl_pkg.sv
src/rst_flr_ctl.sv
bar1/axi_lite_slice.sv
bar1/bar1_regs.sv
src/cl_top.sv
test/clk_gen.sv
test/tb_cl_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_cl_top
FILELIST = filelist.f

.PHONY: sim clean

# Build, run, and pass only when the pass line is in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- test/tb_cl_top.sv
// Testbench for the BAR1 management path with random AXI4-Lite traffic and FLR checked by a model
`include "cl_params.svh"

module tb_cl_top;
  import cl_pkg::*;

  localparam int RST_CYCLES = 5;
  localparam int N_SCRATCH  = 20;
  localparam int N_ERR      = 12;
  localparam int N_BP       = 12;
  localparam int N_FLR      = 3;
  localparam int NUM_TXN    = 2 + 2 * N_SCRATCH + 3 * N_ERR + 3 * N_BP + 2 * (N_FLR + 2);

  logic      clk;
  logic      pipe_rst_n;
  logic      flr_assert;
  logic      flr_done;
  logic      bar1_awvalid;
  logic      bar1_awready;
  addr_t     bar1_awaddr;
  logic      bar1_wvalid;
  logic      bar1_wready;
  data_t     bar1_wdata;
  strb_t     bar1_wstrb;
  logic      bar1_bvalid;
  logic      bar1_bready;
  axi_resp_e bar1_bresp;
  logic      bar1_arvalid;
  logic      bar1_arready;
  addr_t     bar1_araddr;
  logic      bar1_rvalid;
  logic      bar1_rready;
  data_t     bar1_rdata;
  axi_resp_e bar1_rresp;

  // Reference model state
  logic [31:0]           lcg_state;
  data_t                 scratch_m;
  logic [`FLR_CNT_W-1:0] flr_cnt_m;

  clk_gen #(.PERIOD(40)) u_clk_gen (.clk(clk));

  cl_top DUT (
    .clk          (clk),
    .pipe_rst_n   (pipe_rst_n),
    .flr_assert   (flr_assert),
    .flr_done     (flr_done),
    .bar1_awvalid (bar1_awvalid),
    .bar1_awready (bar1_awready),
    .bar1_awaddr  (bar1_awaddr),
    .bar1_wvalid  (bar1_wvalid),
    .bar1_wready  (bar1_wready),
    .bar1_wdata   (bar1_wdata),
    .bar1_wstrb   (bar1_wstrb),
    .bar1_bvalid  (bar1_bvalid),
    .bar1_bready  (bar1_bready),
    .bar1_bresp   (bar1_bresp),
    .bar1_arvalid (bar1_arvalid),
    .bar1_arready (bar1_arready),
    .bar1_araddr  (bar1_araddr),
    .bar1_rvalid  (bar1_rvalid),
    .bar1_rready  (bar1_rready),
    .bar1_rdata   (bar1_rdata),
    .bar1_rresp   (bar1_rresp)
  );

  // ----------------------------
  // Random numbers and model
  // ----------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int pick(input int n);
    return int'(next_rand() >> 8) % n;
  endfunction

  // The four offsets plus high-bit and misaligned unmapped addresses
  function automatic addr_t pick_addr();
    addr_t base;
    base = addr_t'(pick(4)) << 2;
    case (pick(6))
      4: return base | 32'h10 | (next_rand() & 32'hFFFF_FFF0);
      5: return base | addr_t'(1 + pick(3));
      default: return base;
    endcase
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    res = old;
    for (int i = 0; i < $bits(strb_t); i++)
      if (strb[i])
        res[8*i +: 8] = wdata[8*i +: 8];
    return res;
  endfunction

  function automatic data_t exp_rdata(input addr_t addr);
    if (addr == `REG_ID0)
      return `CL_SH_ID0;
    if (addr == `REG_ID1)
      return `CL_SH_ID1;
    if (addr == `REG_SCRATCH)
      return scratch_m;
    if (addr == `REG_FLR_CNT)
      return {{(`DATA_W - `FLR_CNT_W){1'b0}}, flr_cnt_m};
    return '0;
  endfunction

  function automatic axi_resp_e exp_rresp(input addr_t addr);
    if (addr == `REG_ID0 || addr == `REG_ID1 || addr == `REG_SCRATCH || addr == `REG_FLR_CNT)
      return RESP_OKAY;
    return RESP_SLVERR;
  endfunction

  // Only scratch accepts writes
  function automatic axi_resp_e exp_bresp(input addr_t addr);
    return (addr == `REG_SCRATCH) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  // ----------------------------
  // Compare tasks
  // ----------------------------
  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (exp !== act)
    begin
      $display("ERR %s expected %s actual %s (%b)", name, exp.name(), act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------
  // Bus transactions
  // ----------------------------

  // Starts and ends 1 unit after a rising edge
  // A high stall bit holds bready low
  task automatic axi_write(input string name, input addr_t addr, input data_t data,
                           input strb_t strb, input int aw_delay, input int w_delay,
                           input logic [31:0] stall, output axi_resp_e resp);
    int cyc;
    bit aw_done;
    bit w_done;
    bit aw_fire;
    bit w_fire;
    bit held;
    bit taken;
    cyc     = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    held    = 1'b0;
    taken   = 1'b0;
    resp    = RESP_OKAY;
    bar1_awaddr = addr;
    bar1_wdata  = data;
    bar1_wstrb  = strb;
    // Address and data may go in either order
    while (!(aw_done && w_done))
    begin
      bar1_awvalid = !aw_done && (cyc >= aw_delay);
      bar1_wvalid  = !w_done && (cyc >= w_delay);
      @(negedge clk);
      aw_fire = bar1_awvalid && bar1_awready;
      w_fire  = bar1_wvalid && bar1_wready;
      @(posedge clk);
      #1;
      aw_done = aw_done || aw_fire;
      w_done  = w_done || w_fire;
      cyc++;
    end
    bar1_awvalid = 1'b0;
    bar1_wvalid  = 1'b0;
    cyc = 0;
    while (!taken)
    begin
      bar1_bready = !stall[cyc % 32];
      @(negedge clk);
      if (held)
      begin
        check_bit({name, " bvalid held"}, 1'b1, bar1_bvalid);
        check_resp({name, " bresp stable"}, resp, bar1_bresp);
      end
      if (bar1_bvalid)
      begin
        resp  = bar1_bresp;
        held  = 1'b1;
        taken = bar1_bready;
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    bar1_bready = 1'b0;
    // A second response would mean a duplicate
    @(negedge clk);
    check_bit({name, " bvalid once"}, 1'b0, bar1_bvalid);
    @(posedge clk);
    #1;
  endtask

  task automatic axi_read(input string name, input addr_t addr, input int ar_delay,
                          input logic [31:0] stall, output data_t data, output axi_resp_e resp);
    int cyc;
    bit ar_done;
    bit held;
    bit taken;
    cyc     = 0;
    ar_done = 1'b0;
    held    = 1'b0;
    taken   = 1'b0;
    data    = '0;
    resp    = RESP_OKAY;
    bar1_araddr = addr;
    while (!ar_done)
    begin
      bar1_arvalid = (cyc >= ar_delay);
      @(negedge clk);
      ar_done = bar1_arvalid && bar1_arready;
      @(posedge clk);
      #1;
      cyc++;
    end
    bar1_arvalid = 1'b0;
    cyc = 0;
    while (!taken)
    begin
      bar1_rready = !stall[cyc % 32];
      @(negedge clk);
      if (held)
      begin
        check_bit({name, " rvalid held"}, 1'b1, bar1_rvalid);
        check_data({name, " rdata stable"}, data, bar1_rdata);
        check_resp({name, " rresp stable"}, resp, bar1_rresp);
      end
      if (bar1_rvalid)
      begin
        data  = bar1_rdata;
        resp  = bar1_rresp;
        held  = 1'b1;
        taken = bar1_rready;
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    bar1_rready = 1'b0;
    @(negedge clk);
    check_bit({name, " rvalid once"}, 1'b0, bar1_rvalid);
    @(posedge clk);
    #1;
  endtask

  // FLR request held for hold cycles
  // Done is high on the second edge after the request and toggles while it is held
  task automatic run_flr(input string name, input int hold);
    logic done_exp;
    for (int c = 0; c < hold + 3; c++)
    begin
      flr_assert = (c < hold);
      @(posedge clk);
      #1;
      done_exp = (c >= 1) && (c <= hold) && (c % 2 == 1);
      if (done_exp)
        flr_cnt_m = flr_cnt_m + 1'b1;
      check_bit(name, done_exp, flr_done);
    end
    flr_assert = 1'b0;
  endtask

  // ----------------------------
  // Watchdog
  // ----------------------------
  initial
  begin
    repeat (NUM_TXN * 200) @(posedge clk);
    $display("Timeout: no finish after %0d cycles, a handshake never completed",
             NUM_TXN * 200);
    abort_run();
  end

  // ----------------------------
  // Stimulus
  // ----------------------------
  initial
  begin
    addr_t       waddr;
    addr_t       raddr;
    data_t       wdata;
    strb_t       wstrb;
    data_t       rdata;
    axi_resp_e   bresp;
    axi_resp_e   rresp;
    int          d0;
    int          d1;
    int          d2;
    logic [31:0] wstall;
    logic [31:0] rstall;
    string       tname;

    lcg_state    = 32'h6cb;
    scratch_m    = '0;
    flr_cnt_m    = '0;
    pipe_rst_n   = 1'b0;
    flr_assert   = 1'b0;
    bar1_awvalid = 1'b0;
    bar1_awaddr  = '0;
    bar1_wvalid  = 1'b0;
    bar1_wdata   = '0;
    bar1_wstrb   = '0;
    bar1_bready  = 1'b0;
    bar1_arvalid = 1'b0;
    bar1_araddr  = '0;
    bar1_rready  = 1'b0;

    // Reset and a quiet spell before traffic
    repeat (RST_CYCLES)
    begin
      @(posedge clk);
      #1;
      check_bit("reset bvalid", 1'b0, bar1_bvalid);
      check_bit("reset rvalid", 1'b0, bar1_rvalid);
      check_bit("reset awready", 1'b0, bar1_awready);
      check_bit("reset wready", 1'b0, bar1_wready);
      check_bit("reset arready", 1'b0, bar1_arready);
      check_bit("reset flr_done", 1'b0, flr_done);
    end
    pipe_rst_n = 1'b1;
    repeat (4)
    begin
      @(posedge clk);
      #1;
      check_bit("idle bvalid", 1'b0, bar1_bvalid);
      check_bit("idle rvalid", 1'b0, bar1_rvalid);
      check_bit("idle flr_done", 1'b0, flr_done);
    end

    axi_read("id0 read", `REG_ID0, 0, 32'h0, rdata, rresp);
    check_data("id0 read", `CL_SH_ID0, rdata);
    check_resp("id0 read", RESP_OKAY, rresp);
    axi_read("id1 read", `REG_ID1, 0, 32'h0, rdata, rresp);
    check_data("id1 read", `CL_SH_ID1, rdata);
    check_resp("id1 read", RESP_OKAY, rresp);

    // Byte-strobed scratch writes
    for (int n = 0; n < N_SCRATCH; n++)
    begin
      tname = $sformatf("scratch %0d", n);
      wdata = next_rand();
      wstrb = strb_t'(pick(16));
      d0    = pick(3);
      d1    = pick(3);
      d2    = pick(3);
      axi_write(tname, `REG_SCRATCH, wdata, wstrb, d0, d1, 32'h0, bresp);
      check_resp(tname, RESP_OKAY, bresp);
      scratch_m = merge_bytes(scratch_m, wdata, wstrb);
      axi_read(tname, `REG_SCRATCH, d2, 32'h0, rdata, rresp);
      check_data(tname, scratch_m, rdata);
      check_resp(tname, RESP_OKAY, rresp);
    end

    // Writes to read-only or unmapped addresses
    for (int n = 0; n < N_ERR; n++)
    begin
      tname = $sformatf("slverr %0d", n);
      waddr = pick_addr();
      while (waddr == `REG_SCRATCH)
        waddr = pick_addr();
      raddr = pick_addr();
      wdata = next_rand();
      axi_write(tname, waddr, wdata, 4'hF, 0, 0, 32'h0, bresp);
      check_resp(tname, RESP_SLVERR, bresp);
      axi_read(tname, raddr, 0, 32'h0, rdata, rresp);
      check_data(tname, exp_rdata(raddr), rdata);
      check_resp(tname, exp_rresp(raddr), rresp);
      axi_read(tname, `REG_SCRATCH, 0, 32'h0, rdata, rresp);
      check_data(tname, scratch_m, rdata);
    end

    // Concurrent write and read with bready and rready stalls
    for (int n = 0; n < N_BP; n++)
    begin
      tname  = $sformatf("backpressure %0d", n);
      waddr  = pick_addr();
      raddr  = pick_addr();
      while (raddr == `REG_SCRATCH)
        raddr = pick_addr();
      wdata  = next_rand();
      wstrb  = strb_t'(pick(16));
      d0     = pick(3);
      d1     = pick(3);
      d2     = pick(3);
      wstall = next_rand() & 32'h7FFF_FFFF;
      rstall = next_rand() & 32'h7FFF_FFFF;
      fork
        axi_write(tname, waddr, wdata, wstrb, d0, d1, wstall, bresp);
        axi_read(tname, raddr, d2, rstall, rdata, rresp);
      join
      check_resp(tname, exp_bresp(waddr), bresp);
      if (waddr == `REG_SCRATCH)
        scratch_m = merge_bytes(scratch_m, wdata, wstrb);
      check_data(tname, exp_rdata(raddr), rdata);
      check_resp(tname, exp_rresp(raddr), rresp);
      axi_read(tname, `REG_SCRATCH, 0, 32'h0, rdata, rresp);
      check_data(tname, scratch_m, rdata);
    end

    // FLR pulses and a held request
    axi_read("flr count start", `REG_FLR_CNT, 0, 32'h0, rdata, rresp);
    check_data("flr count start", exp_rdata(`REG_FLR_CNT), rdata);
    for (int n = 0; n < N_FLR; n++)
    begin
      tname = $sformatf("flr pulse %0d", n);
      run_flr(tname, 1);
      axi_read(tname, `REG_FLR_CNT, 0, 32'h0, rdata, rresp);
      check_data(tname, exp_rdata(`REG_FLR_CNT), rdata);
      check_resp(tname, RESP_OKAY, rresp);
    end
    run_flr("flr held", 7);
    axi_read("flr held", `REG_FLR_CNT, 0, 32'h0, rdata, rresp);
    check_data("flr held", exp_rdata(`REG_FLR_CNT), rdata);
    check_resp("flr held", RESP_OKAY, rresp);

    $display("No errors");
    $finish;
  end

endmodule

//--- test/clk_gen.sv
// Free-running testbench clock source with a set period
module clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

endmodule

//--- src/cl_top.sv
// Custom-logic top for the BAR1 management path: reset/FLR, register slice, register file
`include "cl_params.svh"

module cl_top (
  input  logic              clk,
  input  logic              pipe_rst_n,
  input  logic              flr_assert,
  output logic              flr_done,

  input  logic              bar1_awvalid,
  output logic              bar1_awready,
  input  cl_pkg::addr_t     bar1_awaddr,
  input  logic              bar1_wvalid,
  output logic              bar1_wready,
  input  cl_pkg::data_t     bar1_wdata,
  input  cl_pkg::strb_t     bar1_wstrb,
  output logic              bar1_bvalid,
  input  logic              bar1_bready,
  output cl_pkg::axi_resp_e bar1_bresp,
  input  logic              bar1_arvalid,
  output logic              bar1_arready,
  input  cl_pkg::addr_t     bar1_araddr,
  output logic              bar1_rvalid,
  input  logic              bar1_rready,
  output cl_pkg::data_t     bar1_rdata,
  output cl_pkg::axi_resp_e bar1_rresp
);
  import cl_pkg::*;

  logic                  sync_rst_n;
  logic [`FLR_CNT_W-1:0] flr_cnt;

  // Slice to register file
  logic      regs_awvalid;
  logic      regs_awready;
  addr_t     regs_awaddr;
  logic      regs_wvalid;
  logic      regs_wready;
  data_t     regs_wdata;
  strb_t     regs_wstrb;
  logic      regs_bvalid;
  logic      regs_bready;
  axi_resp_e regs_bresp;
  logic      regs_arvalid;
  logic      regs_arready;
  addr_t     regs_araddr;
  logic      regs_rvalid;
  logic      regs_rready;
  data_t     regs_rdata;
  axi_resp_e regs_rresp;

  // ----------------------------
  // Reset and FLR
  // ----------------------------
  rst_flr_ctl u_rst_flr_ctl (
    .clk        (clk),
    .pipe_rst_n (pipe_rst_n),
    .flr_assert (flr_assert),
    .sync_rst_n (sync_rst_n),
    .flr_done   (flr_done),
    .flr_cnt    (flr_cnt)
  );

  // ----------------------------
  // BAR1 slice
  // ----------------------------
  axi_lite_slice u_bar1_slice (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .s_awvalid  (bar1_awvalid),
    .s_awready  (bar1_awready),
    .s_awaddr   (bar1_awaddr),
    .s_wvalid   (bar1_wvalid),
    .s_wready   (bar1_wready),
    .s_wdata    (bar1_wdata),
    .s_wstrb    (bar1_wstrb),
    .s_bvalid   (bar1_bvalid),
    .s_bready   (bar1_bready),
    .s_bresp    (bar1_bresp),
    .s_arvalid  (bar1_arvalid),
    .s_arready  (bar1_arready),
    .s_araddr   (bar1_araddr),
    .s_rvalid   (bar1_rvalid),
    .s_rready   (bar1_rready),
    .s_rdata    (bar1_rdata),
    .s_rresp    (bar1_rresp),
    .m_awvalid  (regs_awvalid),
    .m_awready  (regs_awready),
    .m_awaddr   (regs_awaddr),
    .m_wvalid   (regs_wvalid),
    .m_wready   (regs_wready),
    .m_wdata    (regs_wdata),
    .m_wstrb    (regs_wstrb),
    .m_bvalid   (regs_bvalid),
    .m_bready   (regs_bready),
    .m_bresp    (regs_bresp),
    .m_arvalid  (regs_arvalid),
    .m_arready  (regs_arready),
    .m_araddr   (regs_araddr),
    .m_rvalid   (regs_rvalid),
    .m_rready   (regs_rready),
    .m_rdata    (regs_rdata),
    .m_rresp    (regs_rresp)
  );

  // ----------------------------
  // Register file
  // ----------------------------
  bar1_regs u_bar1_regs (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .s_awvalid  (regs_awvalid),
    .s_awready  (regs_awready),
    .s_awaddr   (regs_awaddr),
    .s_wvalid   (regs_wvalid),
    .s_wready   (regs_wready),
    .s_wdata    (regs_wdata),
    .s_wstrb    (regs_wstrb),
    .s_bvalid   (regs_bvalid),
    .s_bready   (regs_bready),
    .s_bresp    (regs_bresp),
    .s_arvalid  (regs_arvalid),
    .s_arready  (regs_arready),
    .s_araddr   (regs_araddr),
    .s_rvalid   (regs_rvalid),
    .s_rready   (regs_rready),
    .s_rdata    (regs_rdata),
    .s_rresp    (regs_rresp),
    .flr_cnt    (flr_cnt)
  );

endmodule

//--- bar1/bar1_regs.sv
// AXI4-Lite slave register file holding the PCI IDs, a scratch word and the FLR count
`include "cl_params.svh"

module bar1_regs (
  input  logic                  clk,
  input  logic                  sync_rst_n,

  input  logic                  s_awvalid,
  output logic                  s_awready,
  input  cl_pkg::addr_t         s_awaddr,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  input  cl_pkg::data_t         s_wdata,
  input  cl_pkg::strb_t         s_wstrb,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  output cl_pkg::axi_resp_e     s_bresp,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  input  cl_pkg::addr_t         s_araddr,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  output cl_pkg::data_t         s_rdata,
  output cl_pkg::axi_resp_e     s_rresp,

  input  logic [`FLR_CNT_W-1:0] flr_cnt
);
  import cl_pkg::*;

  wr_state_e wr_state;
  rd_state_e rd_state;

  logic      aw_got;
  logic      w_got;
  addr_t     aw_addr_q;
  data_t     w_data_q;
  strb_t     w_strb_q;
  data_t     scratch;

  logic      aw_fire;
  logic      w_fire;
  logic      ar_fire;
  logic      aw_have;
  logic      w_have;
  logic      wr_commit;
  logic      wr_ok;
  addr_t     wr_addr;
  data_t     wr_data;
  strb_t     wr_strb;
  data_t     scratch_merged;
  data_t     rd_mux;
  axi_resp_e rd_resp_mux;

  assign aw_fire = s_awvalid && s_awready;
  assign w_fire  = s_wvalid && s_wready;
  assign ar_fire = s_arvalid && s_arready;

  // ----------------------------
  // Write side
  // ----------------------------

  // Either half may come from its latch or straight off the bus
  assign aw_have = aw_got || aw_fire;
  assign w_have  = w_got || w_fire;
  assign wr_addr = aw_got ? aw_addr_q : s_awaddr;
  assign wr_data = w_got ? w_data_q : s_wdata;
  assign wr_strb = w_got ? w_strb_q : s_wstrb;

  assign wr_commit = (wr_state == WR_IDLE) && aw_have && w_have;
  // Scratch is the only writable register
  assign wr_ok     = (wr_addr == `REG_SCRATCH);

  always_comb
  begin
    for (int i = 0; i < $bits(strb_t); i++)
      scratch_merged[8*i +: 8] = wr_strb[i] ? wr_data[8*i +: 8] : scratch[8*i +: 8];
  end

  always_ff @(posedge clk)
  begin
    if (aw_fire)
      aw_addr_q <= s_awaddr;
    if (w_fire)
    begin
      w_data_q <= s_wdata;
      w_strb_q <= s_wstrb;
    end
    if (wr_commit)
      s_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_state  <= WR_IDLE;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      s_awready <= 1'b0;
      s_wready  <= 1'b0;
      scratch   <= '0;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (wr_commit)
          begin
            if (wr_ok)
              scratch <= scratch_merged;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            wr_state  <= WR_RESP;
          end
          else
          begin
            // Close each channel once its half is held
            aw_got    <= aw_have;
            w_got     <= w_have;
            s_awready <= !aw_have;
            s_wready  <= !w_have;
          end
        end
        WR_RESP:
        begin
          if (s_bready)
          begin
            s_awready <= 1'b1;
            s_wready  <= 1'b1;
            wr_state  <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  assign s_bvalid = (wr_state == WR_RESP);

  // ----------------------------
  // Read side
  // ----------------------------
  always_comb
  begin
    rd_resp_mux = RESP_OKAY;
    case (s_araddr)
      `REG_ID0:     rd_mux = `CL_SH_ID0;
      `REG_ID1:     rd_mux = `CL_SH_ID1;
      `REG_SCRATCH: rd_mux = scratch;
      `REG_FLR_CNT: rd_mux = data_t'(flr_cnt);
      default:
      begin
        rd_mux      = '0;
        rd_resp_mux = RESP_SLVERR;
      end
    endcase
  end

  // Data and response stay put while rready is low
  always_ff @(posedge clk)
  begin
    if (ar_fire)
    begin
      s_rdata <= rd_mux;
      s_rresp <= rd_resp_mux;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      rd_state  <= RD_IDLE;
      s_arready <= 1'b0;
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
        begin
          s_arready <= !ar_fire;
          if (ar_fire)
            rd_state <= RD_DATA;
        end
        RD_DATA:
        begin
          if (s_rready)
          begin
            s_arready <= 1'b1;
            rd_state  <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  assign s_rvalid = (rd_state == RD_DATA);

endmodule

//--- bar1/axi_lite_slice.sv
// AXI4-Lite register slice with a one-entry holding stage on each of the five channels
module axi_lite_slice (
  input  logic              clk,
  input  logic              sync_rst_n,

  // Source side, toward the host
  input  logic              s_awvalid,
  output logic              s_awready,
  input  cl_pkg::addr_t     s_awaddr,
  input  logic              s_wvalid,
  output logic              s_wready,
  input  cl_pkg::data_t     s_wdata,
  input  cl_pkg::strb_t     s_wstrb,
  output logic              s_bvalid,
  input  logic              s_bready,
  output cl_pkg::axi_resp_e s_bresp,
  input  logic              s_arvalid,
  output logic              s_arready,
  input  cl_pkg::addr_t     s_araddr,
  output logic              s_rvalid,
  input  logic              s_rready,
  output cl_pkg::data_t     s_rdata,
  output cl_pkg::axi_resp_e s_rresp,

  // Sink side, toward the register file
  output logic              m_awvalid,
  input  logic              m_awready,
  output cl_pkg::addr_t     m_awaddr,
  output logic              m_wvalid,
  input  logic              m_wready,
  output cl_pkg::data_t     m_wdata,
  output cl_pkg::strb_t     m_wstrb,
  input  logic              m_bvalid,
  output logic              m_bready,
  input  cl_pkg::axi_resp_e m_bresp,
  output logic              m_arvalid,
  input  logic              m_arready,
  output cl_pkg::addr_t     m_araddr,
  input  logic              m_rvalid,
  output logic              m_rready,
  input  cl_pkg::data_t     m_rdata,
  input  cl_pkg::axi_resp_e m_rresp
);
  import cl_pkg::*;

  // Channel indices into the flattened stage buses
  localparam int NUM_CH = 5;
  localparam int CH_AW  = 0;
  localparam int CH_WR  = 1;
  localparam int CH_B   = 2;
  localparam int CH_AR  = 3;
  localparam int CH_R   = 4;

  localparam int RESP_W = $bits(axi_resp_e);
  localparam int STRB_W = $bits(strb_t);

  localparam int CH_WIDTH [NUM_CH] = '{$bits(addr_t), $bits(data_t) + STRB_W, RESP_W,
                                       $bits(addr_t), $bits(data_t) + RESP_W};
  localparam int CH_OFS [NUM_CH] = '{0,
                                     CH_WIDTH[0],
                                     CH_WIDTH[0] + CH_WIDTH[1],
                                     CH_WIDTH[0] + CH_WIDTH[1] + CH_WIDTH[2],
                                     CH_WIDTH[0] + CH_WIDTH[1] + CH_WIDTH[2] + CH_WIDTH[3]};
  localparam int BUS_W = CH_OFS[NUM_CH-1] + CH_WIDTH[NUM_CH-1];

  logic [NUM_CH-1:0] in_valid;
  logic [NUM_CH-1:0] in_ready;
  logic [NUM_CH-1:0] out_valid;
  logic [NUM_CH-1:0] out_ready;
  logic [BUS_W-1:0]  in_bus;
  logic [BUS_W-1:0]  out_bus;
  logic              slice_en;

  // Keeps every ready low until the reset has been released
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      slice_en <= 1'b0;
    else
      slice_en <= 1'b1;
  end

  // ----------------------------
  // Holding stages
  // ----------------------------
  for (genvar i = 0; i < NUM_CH; i++)
  begin : g_stage
    logic                   full;
    logic [CH_WIDTH[i]-1:0] hold;

    // Accept when empty or when the held entry leaves this cycle
    assign in_ready[i]  = slice_en && (!full || out_ready[i]);
    assign out_valid[i] = full;
    assign out_bus[CH_OFS[i] +: CH_WIDTH[i]] = hold;

    always_ff @(posedge clk)
    begin
      if (!sync_rst_n)
        full <= 1'b0;
      else if (in_valid[i] && in_ready[i])
        full <= 1'b1;
      else if (out_ready[i])
        full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
      if (in_valid[i] && in_ready[i])
        hold <= in_bus[CH_OFS[i] +: CH_WIDTH[i]];
    end
  end

  // ----------------------------
  // Requests, s_ to m_
  // ----------------------------
  assign in_valid[CH_AW]  = s_awvalid;
  assign s_awready        = in_ready[CH_AW];
  assign m_awvalid        = out_valid[CH_AW];
  assign out_ready[CH_AW] = m_awready;
  assign in_bus[CH_OFS[CH_AW] +: CH_WIDTH[CH_AW]] = s_awaddr;
  assign m_awaddr = out_bus[CH_OFS[CH_AW] +: CH_WIDTH[CH_AW]];

  assign in_valid[CH_WR]  = s_wvalid;
  assign s_wready         = in_ready[CH_WR];
  assign m_wvalid         = out_valid[CH_WR];
  assign out_ready[CH_WR] = m_wready;
  assign in_bus[CH_OFS[CH_WR] +: CH_WIDTH[CH_WR]] = {s_wdata, s_wstrb};
  assign {m_wdata, m_wstrb} = out_bus[CH_OFS[CH_WR] +: CH_WIDTH[CH_WR]];

  assign in_valid[CH_AR]  = s_arvalid;
  assign s_arready        = in_ready[CH_AR];
  assign m_arvalid        = out_valid[CH_AR];
  assign out_ready[CH_AR] = m_arready;
  assign in_bus[CH_OFS[CH_AR] +: CH_WIDTH[CH_AR]] = s_araddr;
  assign m_araddr = out_bus[CH_OFS[CH_AR] +: CH_WIDTH[CH_AR]];

  // ----------------------------
  // Responses, m_ to s_
  // ----------------------------
  assign in_valid[CH_B]  = m_bvalid;
  assign m_bready        = in_ready[CH_B];
  assign s_bvalid        = out_valid[CH_B];
  assign out_ready[CH_B] = s_bready;
  assign in_bus[CH_OFS[CH_B] +: CH_WIDTH[CH_B]] = m_bresp;
  assign s_bresp = axi_resp_e'(out_bus[CH_OFS[CH_B] +: CH_WIDTH[CH_B]]);

  assign in_valid[CH_R]  = m_rvalid;
  assign m_rready        = in_ready[CH_R];
  assign s_rvalid        = out_valid[CH_R];
  assign out_ready[CH_R] = s_rready;
  assign in_bus[CH_OFS[CH_R] +: CH_WIDTH[CH_R]] = {m_rdata, m_rresp};
  assign s_rdata = out_bus[CH_OFS[CH_R] + RESP_W +: $bits(data_t)];
  assign s_rresp = axi_resp_e'(out_bus[CH_OFS[CH_R] +: RESP_W]);

endmodule

//--- src/rst_flr_ctl.sv
// Block reset generation and function-level-reset acknowledge with request counter
`include "cl_params.svh"

module rst_flr_ctl (
  input  logic                  clk,
  input  logic                  pipe_rst_n,
  input  logic                  flr_assert,
  output logic                  sync_rst_n,
  output logic                  flr_done,
  output logic [`FLR_CNT_W-1:0] flr_cnt
);

  logic [`SYNC_STAGES-1:0] rst_chain;
  logic                    flr_assert_q;
  logic                    flr_pulse;

  // ----------------------------
  // Block reset
  // ----------------------------

  // Ones shift in once the pipelined reset is released
  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n)
      rst_chain <= '0;
    else
      rst_chain <= {rst_chain[`SYNC_STAGES-2:0], 1'b1};
  end

  assign sync_rst_n = rst_chain[`SYNC_STAGES-1];

  // ----------------------------
  // FLR acknowledge
  // ----------------------------

  // Next done value, high on every cycle done rises
  assign flr_pulse = flr_assert_q && !flr_done;

  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n || !sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
      flr_cnt      <= '0;
    end
    else
    begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_pulse;
      // Wraps at the counter width
      if (flr_pulse)
        flr_cnt <= flr_cnt + 1'b1;
    end
  end

endmodule

//--- common/cl_pkg.sv
// Shared types for the BAR1 AXI4-Lite path and its register file
`include "cl_params.svh"

package cl_pkg;

  // ----------------------------
  // Bus payload types
  // ----------------------------
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`STRB_W-1:0] strb_t;

  // AXI response codes, only the two the register file returns
  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // ----------------------------
  // Register file FSMs
  // ----------------------------

  // Collecting aw and w, or holding the write response
  typedef enum logic
  {
    WR_IDLE = 1'b0,
    WR_RESP = 1'b1
  } wr_state_e;

  // Waiting for ar, or holding read data
  typedef enum logic
  {
    RD_IDLE = 1'b0,
    RD_DATA = 1'b1
  } rd_state_e;

endpackage

//--- common/cl_params.svh
// Constants for the BAR1 management path: IDs, register map, widths, reset depth
`ifndef CL_PARAMS_SVH
`define CL_PARAMS_SVH

// ----------------------------
// PCI ID words
// ----------------------------
`define CL_SH_ID0 32'hF000_1D0F
`define CL_SH_ID1 32'h1D51_FEDD

// ----------------------------
// BAR1 register map
// ----------------------------
`define REG_ID0     32'h0000_0000
`define REG_ID1     32'h0000_0004
`define REG_SCRATCH 32'h0000_0008
`define REG_FLR_CNT 32'h0000_000C

// ----------------------------
// Widths
// ----------------------------
`define ADDR_W    32
`define DATA_W    32
`define STRB_W    (`DATA_W / 8)
`define FLR_CNT_W 16

// Flops in the block reset chain
`define SYNC_STAGES 2

`endif
